// ==== flist.f ====
hdl/rename_pkg.sv
hdl/reg_file.sv
hdl/reorder_buffer.sv
hdl/operand_resolve.sv
hdl/rename_core.sv
tb/rename_core_checker.sv
tb/rename_core_tb.sv

// ==== hdl/operand_resolve.sv ====
`default_nettype none

module operand_resolve
    import rename_pkg::*;
(
    // raw register file reads
    input  wire value_t   val1,
    input  wire value_t   val2,
    input  wire rob_tag_t lab1,
    input  wire rob_tag_t lab2,

    // reorder buffer lookups
    output rob_tag_t      look_tag1,
    output rob_tag_t      look_tag2,
    input  wire logic     look_done1,
    input  wire logic     look_done2,
    input  wire value_t   look_val1,
    input  wire value_t   look_val2,

    output operand_t      op1,
    output operand_t      op2
);

    function automatic operand_t resolve(
        input value_t   reg_val,
        input rob_tag_t lab,
        input logic     done,
        input value_t   rob_val
    );
        operand_t op;
        if (lab == '0) begin
            // no pending writer, register value is current
            op.ready = 1'b1;
            op.tag   = '0;
            op.value = reg_val;
        end else if (done) begin
            // written back but not yet committed
            op.ready = 1'b1;
            op.tag   = '0;
            op.value = rob_val;
        end else begin
            op.ready = 1'b0;
            op.tag   = lab;
            op.value = '0;
        end
        return op;
    endfunction

    assign look_tag1 = lab1;
    assign look_tag2 = lab2;

    assign op1 = resolve(val1, lab1, look_done1, look_val1);
    assign op2 = resolve(val2, lab2, look_done2, look_val2);

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

module reg_file
    import rename_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_in,
    input  wire logic     rdy_in,
    input  wire logic     flush,

    // labelling from issue
    input  wire logic     issue_en,
    input  wire reg_idx_t issue_rd,
    input  wire rob_tag_t issue_tag,

    // in-order retirement from the reorder buffer
    input  wire logic     commit_valid,
    input  wire commit_t  commit,

    // source reads
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    output value_t        val1,
    output value_t        val2,
    output rob_tag_t      lab1,
    output rob_tag_t      lab2
);

    value_t   values [REG_SIZE];
    rob_tag_t labels [REG_SIZE];

    logic do_issue;
    logic do_commit;

    // x0 is hardwired, never labelled or written
    assign do_issue  = issue_en && (issue_rd != '0);
    assign do_commit = commit_valid && (commit.rd != '0);

    always_ff @(posedge clk) begin
        if (rst_in) begin
            for (int i = 0; i < REG_SIZE; i++) begin
                values[i] <= '0;
                labels[i] <= '0;
            end
        end else if (rdy_in) begin
            if (flush) begin
                // drop all renames, committed values stay
                for (int i = 0; i < REG_SIZE; i++) begin
                    labels[i] <= '0;
                end
            end else begin
                if (do_commit) begin
                    values[commit.rd] <= commit.value;
                    // a newer writer keeps its label
                    if (labels[commit.rd] == commit.tag) begin
                        labels[commit.rd] <= '0;
                    end
                end
                // issue comes last so a same-cycle rename wins
                if (do_issue) begin
                    labels[issue_rd] <= issue_tag;
                end
            end
        end
    end

    // combinational reads, state before the edge
    assign val1 = values[rs1];
    assign val2 = values[rs2];
    assign lab1 = labels[rs1];
    assign lab2 = labels[rs2];

endmodule

`default_nettype wire

// ==== hdl/rename_core.sv ====
`default_nettype none

module rename_core
    import rename_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_in,
    input  wire logic       rdy_in,
    input  wire logic       flush,

    input  wire logic       issue_en,
    input  wire issue_req_t issue,
    input  wire logic       wb_en,
    input  wire wb_req_t    wb,

    output rob_tag_t        issue_tag,
    output logic            rob_full,
    output operand_t        op1,
    output operand_t        op2,
    output logic            commit_valid,
    output commit_t         commit
);

    value_t   val1;
    value_t   val2;
    rob_tag_t lab1;
    rob_tag_t lab2;

    rob_tag_t look_tag1;
    rob_tag_t look_tag2;
    logic     look_done1;
    logic     look_done2;
    value_t   look_val1;
    value_t   look_val2;

    reg_file u_reg_file (
        .clk          (clk),
        .rst_in       (rst_in),
        .rdy_in       (rdy_in),
        .flush        (flush),
        .issue_en     (issue_en),
        .issue_rd     (issue.rd),
        .issue_tag    (issue_tag),
        .commit_valid (commit_valid),
        .commit       (commit),
        .rs1          (issue.rs1),
        .rs2          (issue.rs2),
        .val1         (val1),
        .val2         (val2),
        .lab1         (lab1),
        .lab2         (lab2)
    );

    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .rst_in       (rst_in),
        .rdy_in       (rdy_in),
        .flush        (flush),
        .issue_en     (issue_en),
        .issue_rd     (issue.rd),
        .issue_tag    (issue_tag),
        .rob_full     (rob_full),
        .wb_en        (wb_en),
        .wb           (wb),
        .look_tag1    (look_tag1),
        .look_tag2    (look_tag2),
        .look_done1   (look_done1),
        .look_done2   (look_done2),
        .look_val1    (look_val1),
        .look_val2    (look_val2),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    operand_resolve u_operand_resolve (
        .val1       (val1),
        .val2       (val2),
        .lab1       (lab1),
        .lab2       (lab2),
        .look_tag1  (look_tag1),
        .look_tag2  (look_tag2),
        .look_done1 (look_done1),
        .look_done2 (look_done2),
        .look_val1  (look_val1),
        .look_val2  (look_val2),
        .op1        (op1),
        .op2        (op2)
    );

endmodule

`default_nettype wire

// ==== hdl/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // architectural register file
    localparam int REG_SIZE = 32;
    localparam int REG_WIDTH = 5;
    localparam int VAL_WIDTH = 32;

    // reorder buffer
    localparam int ROB_SIZE = 8;
    localparam int ROB_ID_WIDTH = 3;

    typedef logic [REG_WIDTH-1:0] reg_idx_t;
    typedef logic [VAL_WIDTH-1:0] value_t;

    // tag 0 means no pending writer, entry k carries tag k+1
    typedef logic [ROB_ID_WIDTH:0] rob_tag_t;
    typedef logic [ROB_ID_WIDTH-1:0] rob_idx_t;
    typedef logic [ROB_ID_WIDTH:0] rob_count_t;

    typedef enum logic [1:0] {
        ROB_EMPTY,
        ROB_WAITING,
        ROB_DONE
    } rob_state_e;

    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } issue_req_t;

    typedef struct packed {
        rob_tag_t tag;
        value_t   value;
    } wb_req_t;

    typedef struct packed {
        reg_idx_t rd;
        rob_tag_t tag;
        value_t   value;
    } commit_t;

    // ready operands carry a value, waiting ones the producer tag
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        value_t   value;
    } operand_t;

endpackage

`default_nettype wire

// ==== hdl/reorder_buffer.sv ====
`default_nettype none

module reorder_buffer
    import rename_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_in,
    input  wire logic     rdy_in,
    input  wire logic     flush,

    // allocation at the tail
    input  wire logic     issue_en,
    input  wire reg_idx_t issue_rd,
    output rob_tag_t      issue_tag,
    output logic          rob_full,

    // result capture
    input  wire logic     wb_en,
    input  wire wb_req_t  wb,

    // operand lookups
    input  wire rob_tag_t look_tag1,
    input  wire rob_tag_t look_tag2,
    output logic          look_done1,
    output logic          look_done2,
    output value_t        look_val1,
    output value_t        look_val2,

    // retirement at the head
    output logic          commit_valid,
    output commit_t       commit
);

    rob_state_e state_q [ROB_SIZE];
    reg_idx_t   rd_q    [ROB_SIZE];
    value_t     val_q   [ROB_SIZE];

    rob_idx_t   head;
    rob_idx_t   tail;
    rob_count_t count;

    rob_idx_t   wb_idx;
    logic       do_issue;
    logic       do_wb;

    function automatic rob_idx_t tag_idx(input rob_tag_t t);
        rob_tag_t d;
        d = t - rob_tag_t'(1);
        return d[ROB_ID_WIDTH-1:0];
    endfunction

    function automatic rob_tag_t idx_tag(input rob_idx_t idx);
        return rob_tag_t'(idx) + rob_tag_t'(1);
    endfunction

    assign issue_tag = idx_tag(tail);
    assign rob_full  = (count == rob_count_t'(ROB_SIZE));

    // nothing moves while stalled or flushing
    assign do_issue = issue_en && rdy_in && !flush && !rob_full;

    // writebacks to a free or finished entry are ignored
    assign wb_idx = tag_idx(wb.tag);
    assign do_wb  = wb_en && rdy_in && !flush && (wb.tag != '0)
                    && (state_q[wb_idx] == ROB_WAITING);

    // head retires as soon as its result is in
    assign commit_valid = rdy_in && !flush && (state_q[head] == ROB_DONE);
    assign commit.rd    = rd_q[head];
    assign commit.tag   = idx_tag(head);
    assign commit.value = val_q[head];

    always_ff @(posedge clk) begin
        if (rst_in || (rdy_in && flush)) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_SIZE; i++) begin
                state_q[i] <= ROB_EMPTY;
            end
        end else if (rdy_in) begin
            if (commit_valid) begin
                state_q[head] <= ROB_EMPTY;
                head          <= head + rob_idx_t'(1);
            end
            // a waiting entry is never the committing head
            if (do_wb) begin
                state_q[wb_idx] <= ROB_DONE;
            end
            if (do_issue) begin
                state_q[tail] <= ROB_WAITING;
                tail          <= tail + rob_idx_t'(1);
            end
            case ({do_issue, commit_valid})
                2'b10:   count <= count + rob_count_t'(1);
                2'b01:   count <= count - rob_count_t'(1);
                default: count <= count;
            endcase
        end
    end

    // entry payload, qualified by state
    always_ff @(posedge clk) begin
        if (do_issue) begin
            rd_q[tail] <= issue_rd;
        end
        if (do_wb) begin
            val_q[wb_idx] <= wb.value;
        end
    end

    // tag zero never names an entry
    assign look_done1 = (look_tag1 != '0) && (state_q[tag_idx(look_tag1)] == ROB_DONE);
    assign look_done2 = (look_tag2 != '0) && (state_q[tag_idx(look_tag2)] == ROB_DONE);
    assign look_val1  = val_q[tag_idx(look_tag1)];
    assign look_val2  = val_q[tag_idx(look_tag2)];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the rename core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f flist.f \
    --top-module rename_core_tb \
    --Mdir obj_dir -o rename_core_sim

# the simulator status is not used, the log decides
./obj_dir/rename_core_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== tb/rename_core_checker.sv ====
`default_nettype none

module rename_core_checker
    import rename_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst_in,
    input wire logic       rdy_in,
    input wire logic       flush,
    input wire logic       issue_en,
    input wire logic       rob_full,
    input wire logic       commit_valid,
    input wire commit_t    commit
);

    // tag the head must carry at its next commit
    rob_tag_t   next_commit_tag;
    // entries in flight, from accepted issues and commits
    rob_count_t occupancy;
    logic       accepted;
    // sticky, watched by the testbench
    logic       violation;

    initial violation = 1'b0;

    assign accepted = issue_en && rdy_in && !flush && !rob_full;

    always_ff @(posedge clk) begin
        if (rst_in || (rdy_in && flush)) begin
            next_commit_tag <= rob_tag_t'(1);
        end else if (commit_valid) begin
            if (next_commit_tag == rob_tag_t'(ROB_SIZE)) begin
                next_commit_tag <= rob_tag_t'(1);
            end else begin
                next_commit_tag <= next_commit_tag + rob_tag_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in || (rdy_in && flush)) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + rob_count_t'(accepted) - rob_count_t'(commit_valid);
        end
    end

    a_no_commit_in_reset: assert property (@(posedge clk)
        rst_in && $past(rst_in) |-> !commit_valid)
        else begin
            violation = 1'b1;
            $error("commit_valid high while reset is held");
        end

    a_full_count: assert property (@(posedge clk) disable iff (rst_in)
        rob_full |-> occupancy == rob_count_t'(ROB_SIZE))
        else begin
            violation = 1'b1;
            $error("rob_full high with %0d entries in flight", occupancy);
        end

    // tags retire in allocation order, wrapping after ROB_SIZE
    a_commit_order: assert property (@(posedge clk) disable iff (rst_in)
        commit_valid |-> commit.tag == next_commit_tag)
        else begin
            violation = 1'b1;
            $error("commit tag %0d out of order, %0d due", commit.tag, next_commit_tag);
        end

    // nothing left to retire right after a flush
    a_no_commit_on_flush: assert property (@(posedge clk) disable iff (rst_in)
        rdy_in && flush |=> !commit_valid)
        else begin
            violation = 1'b1;
            $error("commit_valid high in the cycle after a flush");
        end

endmodule

`default_nettype wire

// ==== tb/rename_core_tb.sv ====
`default_nettype none

module rename_core_tb
    import rename_pkg::*;
();

    localparam int RESET_CYCLES   = 8;
    localparam int RAND_CYCLES    = 200;
    localparam int PLANNED_CYCLES = RESET_CYCLES + 2 * RAND_CYCLES + 120;
    localparam int TIMEOUT        = PLANNED_CYCLES * 10 + 500;

    logic       clk;
    logic       rst_in;
    logic       rdy_in;
    logic       flush;
    logic       issue_en;
    issue_req_t issue;
    logic       wb_en;
    wb_req_t    wb;
    rob_tag_t   issue_tag;
    logic       rob_full;
    operand_t   op1;
    operand_t   op2;
    logic       commit_valid;
    commit_t    commit;

    // reference model, per-tag arrays indexed by tag
    value_t   m_val [REG_SIZE];
    rob_tag_t m_lab [REG_SIZE];
    rob_tag_t pend [$];
    reg_idx_t ent_rd [16];
    logic     ent_done [16];
    value_t   ent_val [16];
    rob_tag_t m_next_tag;

    // expectations for the coming edge
    operand_t exp_op1;
    operand_t exp_op2;
    logic     exp_cv;
    commit_t  exp_commit;
    logic     exp_full;
    rob_tag_t exp_tag;

    rename_core dut (
        .clk          (clk),
        .rst_in       (rst_in),
        .rdy_in       (rdy_in),
        .flush        (flush),
        .issue_en     (issue_en),
        .issue        (issue),
        .wb_en        (wb_en),
        .wb           (wb),
        .issue_tag    (issue_tag),
        .rob_full     (rob_full),
        .op1          (op1),
        .op2          (op2),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    bind reorder_buffer rename_core_checker u_checker (
        .clk          (clk),
        .rst_in       (rst_in),
        .rdy_in       (rdy_in),
        .flush        (flush),
        .issue_en     (issue_en),
        .rob_full     (rob_full),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("[ERROR] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        fail_run();
    endtask

    function automatic operand_t expect_operand(input reg_idx_t rs);
        operand_t op;
        rob_tag_t lab;
        op  = '0;
        lab = m_lab[rs];
        if (lab == '0) begin
            op.ready = 1'b1;
            op.value = m_val[rs];
        end else if (ent_done[lab]) begin
            // written back, not committed yet
            op.ready = 1'b1;
            op.value = ent_val[lab];
        end else begin
            op.tag = lab;
        end
        return op;
    endfunction

    // a waiting operand only has a meaningful tag, a ready one only a value
    function automatic logic same_operand(input operand_t a, input operand_t e);
        return (a.ready == e.ready) && (e.ready ? (a.value == e.value) : (a.tag == e.tag));
    endfunction

    a_op1: assert property (@(posedge clk) disable iff (rst_in) same_operand(op1, exp_op1))
        else report_mismatch("op1", 64'(exp_op1), 64'($sampled(op1)));
    a_op2: assert property (@(posedge clk) disable iff (rst_in) same_operand(op2, exp_op2))
        else report_mismatch("op2", 64'(exp_op2), 64'($sampled(op2)));
    a_commit_valid: assert property (@(posedge clk) disable iff (rst_in) commit_valid == exp_cv)
        else report_mismatch("commit_valid", 64'(exp_cv), 64'($sampled(commit_valid)));
    a_commit: assert property (@(posedge clk) disable iff (rst_in)
        !exp_cv || (commit == exp_commit))
        else report_mismatch("commit", 64'(exp_commit), 64'($sampled(commit)));
    a_issue_tag: assert property (@(posedge clk) disable iff (rst_in) issue_tag == exp_tag)
        else report_mismatch("issue_tag", 64'(exp_tag), 64'($sampled(issue_tag)));
    a_rob_full: assert property (@(posedge clk) disable iff (rst_in) rob_full == exp_full)
        else report_mismatch("rob_full", 64'(exp_full), 64'($sampled(rob_full)));

    // reorder buffer invariants from the bound checker
    always @(negedge clk) begin
        if (dut.u_reorder_buffer.u_checker.violation) begin
            $display("a reorder buffer invariant assertion failed");
            fail_run();
        end
    end

    task automatic predict();
        rob_tag_t h;
        exp_op1    = expect_operand(issue.rs1);
        exp_op2    = expect_operand(issue.rs2);
        exp_tag    = m_next_tag;
        exp_full   = (pend.size() == ROB_SIZE);
        exp_cv     = 1'b0;
        exp_commit = '0;
        if (pend.size() != 0) begin
            h                = pend[0];
            exp_cv           = rdy_in && !flush && ent_done[h];
            exp_commit.rd    = ent_rd[h];
            exp_commit.tag   = h;
            exp_commit.value = ent_val[h];
        end
    endtask

    // state change at an edge, from the inputs held across it
    task automatic update_model();
        rob_tag_t h;
        if (rdy_in && flush) begin
            pend.delete();
            m_next_tag = rob_tag_t'(1);
            for (int i = 0; i < REG_SIZE; i++) begin
                m_lab[i] = '0;
            end
            for (int i = 0; i < 16; i++) begin
                ent_done[i] = 1'b0;
            end
        end else if (rdy_in) begin
            if (exp_cv) begin
                h = pend.pop_front();
                ent_done[h] = 1'b0;
                if (ent_rd[h] != '0) begin
                    m_val[ent_rd[h]] = ent_val[h];
                    if (m_lab[ent_rd[h]] == h) begin
                        m_lab[ent_rd[h]] = '0;
                    end
                end
            end
            if (wb_en) begin
                ent_done[wb.tag] = 1'b1;
                ent_val[wb.tag]  = wb.value;
            end
            if (issue_en && !exp_full) begin
                pend.push_back(m_next_tag);
                ent_rd[m_next_tag]   = issue.rd;
                ent_done[m_next_tag] = 1'b0;
                if (issue.rd != '0) begin
                    m_lab[issue.rd] = m_next_tag;
                end
                if (m_next_tag == rob_tag_t'(ROB_SIZE)) begin
                    m_next_tag = rob_tag_t'(1);
                end else begin
                    m_next_tag = m_next_tag + rob_tag_t'(1);
                end
            end
        end
    endtask

    task automatic clear_strobes();
        issue_en  = 1'b0;
        wb_en     = 1'b0;
        flush     = 1'b0;
        issue.rd  = '0;
        issue.rs1 = reg_idx_t'($urandom_range(7));
        issue.rs2 = reg_idx_t'($urandom_range(7));
    endtask

    task automatic step();
        predict();
        @(posedge clk);
        update_model();
        #1;
        clear_strobes();
    endtask

    task automatic drive_issue(input reg_idx_t rd);
        if (pend.size() < ROB_SIZE) begin
            issue_en = 1'b1;
            issue.rd = rd;
        end
    endtask

    // random pending entry without a result, so results arrive out of order
    task automatic drive_wb();
        rob_tag_t cand [$];
        foreach (pend[i]) begin
            if (!ent_done[pend[i]]) begin
                cand.push_back(pend[i]);
            end
        end
        if (cand.size() != 0) begin
            wb_en    = 1'b1;
            wb.tag   = cand[$urandom_range(cand.size() - 1)];
            wb.value = $urandom;
        end
    endtask

    task automatic random_cycle();
        rdy_in = ($urandom_range(7) != 0);
        if ($urandom_range(1) != 0) begin
            drive_issue(reg_idx_t'($urandom_range(7)));
        end
        if ($urandom_range(1) != 0) begin
            drive_wb();
        end
        step();
    endtask

    task automatic drain();
        while (pend.size() != 0) begin
            drive_wb();
            step();
        end
    endtask

    initial begin
        void'($urandom(32'hf47e_cf96));
        rst_in = 1'b1;
        rdy_in = 1'b1;
        wb     = '0;
        issue  = '0;
        clear_strobes();
        pend.delete();
        m_next_tag = rob_tag_t'(1);
        for (int i = 0; i < REG_SIZE; i++) begin
            m_val[i] = '0;
            m_lab[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            ent_rd[i]   = '0;
            ent_done[i] = 1'b0;
            ent_val[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_in = 1'b0;

        // idle reads right after reset
        repeat (4) step();
        // mixed issue, writeback and stalls
        repeat (RAND_CYCLES) random_cycle();
        rdy_in = 1'b1;
        drain();

        // stall with traffic on the inputs, head result already in
        drive_issue(5'd3);
        step();
        drive_issue(5'd4);
        drive_wb();
        step();
        repeat (4) begin
            rdy_in = 1'b0;
            drive_issue(5'd5);
            drive_wb();
            step();
        end
        rdy_in = 1'b1;
        drain();

        // fill the buffer without results
        while (pend.size() < ROB_SIZE) begin
            drive_issue(reg_idx_t'($urandom_range(1, 7)));
            step();
        end
        repeat (2) step();
        drain();

        // flush with work in flight
        repeat (4) begin
            drive_issue(reg_idx_t'($urandom_range(7)));
            step();
        end
        // oldest result in, so a commit is due at the flush
        while (!ent_done[pend[0]]) begin
            drive_wb();
            step();
        end
        flush = 1'b1;
        step();
        repeat (4) step();

        repeat (RAND_CYCLES) random_cycle();
        rdy_in = 1'b1;
        drain();
        repeat (2) step();

        if (!dut.u_reorder_buffer.u_checker.violation) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run();
        end
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired after %0d time units", TIMEOUT);
        fail_run();
    end

endmodule

`default_nettype wire
